// File: filelist.f
hdl/simd_pkg.sv
hdl/simd_lane_if.sv
hdl/simd_operand_prep.sv
hdl/simd_lane.sv
hdl/simd_result_merge.sv
hdl/simd_unit.sv
tb/tb_clock_gen.sv
tb/simd_unit_properties.sv
tb/simd_unit_tb.sv

// File: hdl/simd_lane.sv
/*
 * One 64-bit lane: per-SEW element ALU, compares and moves,
 * with registered element result and compare bits
 */
`timescale 1ns/10ps
`default_nettype none

module simd_lane #(
    parameter int VLEN     = 128,
    parameter int LANE_IDX = 0
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    simd_lane_if.lane                 lane_bus,
    output logic [simd_pkg::ELEN-1:0] elem_o,
    output logic [7:0]                cmp_o
);
    import simd_pkg::*;

    localparam int LANES = VLEN / ELEN;
    localparam int SLOT  = (LANE_IDX < LANES) ? LANE_IDX : 0; // Stay inside the bus arrays

    logic [ELEN-1:0] op1;
    logic [ELEN-1:0] vs2;
    logic [7:0]      msk;

    logic [ELEN-1:0] sew_res [4];  // Result for each element width
    logic [7:0]      sew_cmp [4];
    logic [ELEN-1:0] elem_d;
    logic [7:0]      cmp_d;

    assign op1 = lane_bus.vs1_elem[SLOT];
    assign vs2 = lane_bus.vs2_elem[SLOT];
    assign msk = lane_bus.mask_elem[SLOT];

    // Same datapath built once per width, SEW picks one afterwards
    for (genvar w = 0; w < 4; w++) begin : g_sew
        localparam int SW   = 8 << w;
        localparam int NSUB = ELEN / SW;

        logic [SW-1:0] a;  // vs2 sub-element
        logic [SW-1:0] b;  // Operand 1 sub-element

        always_comb begin
            sew_res[w] = '0;
            sew_cmp[w] = '0;
            for (int e = 0; e < NSUB; e++) begin
                a = vs2[e*SW +: SW];
                b = op1[e*SW +: SW];
                if (is_compare(lane_bus.op)) begin
                    case (lane_bus.op)
                        VMSEQ:   sew_cmp[w][e] = (a == b);
                        VMSLT:   sew_cmp[w][e] = ($signed(a) < $signed(b));
                        default: sew_cmp[w][e] = (a < b);  // VMSLTU
                    endcase
                end else begin
                    case (lane_bus.op)
                        VADD:    sew_res[w][e*SW +: SW] = a + b;
                        VSUB:    sew_res[w][e*SW +: SW] = a - b;
                        VAND:    sew_res[w][e*SW +: SW] = a & b;
                        VOR:     sew_res[w][e*SW +: SW] = a | b;
                        VXOR:    sew_res[w][e*SW +: SW] = a ^ b;
                        // vmerge is always masked, inactive elements keep vs2
                        VMERGE:  sew_res[w][e*SW +: SW] = msk[e] ? b : a;
                        default: sew_res[w][e*SW +: SW] = a;  // VMV_X_S
                    endcase
                end
            end
        end
    end

    always_comb begin
        elem_d = sew_res[lane_bus.sew];
        cmp_d  = sew_cmp[lane_bus.sew];
        // Only lane 0 holds element 0 for vmv.x.s
        if (lane_bus.op == VMV_X_S && LANE_IDX != 0) begin
            elem_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            elem_o <= '0;
            cmp_o  <= '0;
        end else if (lane_bus.valid) begin
            elem_o <= elem_d;
            cmp_o  <= cmp_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/simd_lane_if.sv
/*
 * Lane operand bus: per-lane vs1/vs2 words, mask slice and shared control
 */
`timescale 1ns/10ps
`default_nettype none

interface simd_lane_if #(
    parameter int VLEN = 128
);
    import simd_pkg::*;

    localparam int LANES = VLEN / ELEN;

    logic                       valid;
    simd_op_e                   op;
    sew_e                       sew;
    logic [LANES-1:0][ELEN-1:0] vs1_elem;   // Operand 1, already replicated
    logic [LANES-1:0][ELEN-1:0] vs2_elem;
    logic [LANES-1:0][7:0]      mask_elem;  // One bit per sub-element of the lane

    modport prep (
        output valid, op, sew, vs1_elem, vs2_elem, mask_elem
    );

    modport lane (
        input valid, op, sew, vs1_elem, vs2_elem, mask_elem
    );

endinterface

`default_nettype wire

// File: hdl/simd_operand_prep.sv
/*
 * Operand preparation: immediate sign extension, scalar replication by SEW,
 * operand 1 source select and the split of operands and mask into lanes
 */
`timescale 1ns/10ps
`default_nettype none

module simd_operand_prep #(
    parameter int VLEN = 128
) (
    input  logic                       valid_i,
    input  simd_pkg::simd_op_e         op_i,
    input  simd_pkg::sew_e             sew_i,
    input  simd_pkg::src_sel_e         src_sel_i,
    input  logic [VLEN-1:0]            vs1_i,
    input  logic [VLEN-1:0]            vs2_i,
    input  logic [VLEN-1:0]            mask_i,
    input  logic [63:0]                rs1_i,
    input  logic [simd_pkg::IMM_W-1:0] imm_i,
    simd_lane_if.prep                  lane_bus
);
    import simd_pkg::*;

    localparam int LANES = VLEN / ELEN;

    logic [63:0]     imm_ext;
    logic [63:0]     scalar;
    logic [VLEN-1:0] scalar_rep;
    logic [VLEN-1:0] op1;

    assign imm_ext = {{(64-IMM_W){imm_i[IMM_W-1]}}, imm_i};
    assign scalar  = (src_sel_i == SRC_VI) ? imm_ext : rs1_i;

    // Low SEW bits of the scalar fill every element
    always_comb begin
        case (sew_i)
            SEW_8:   scalar_rep = {(VLEN/8){scalar[7:0]}};
            SEW_16:  scalar_rep = {(VLEN/16){scalar[15:0]}};
            SEW_32:  scalar_rep = {(VLEN/32){scalar[31:0]}};
            default: scalar_rep = {(VLEN/64){scalar}};
        endcase
    end

    assign op1 = (src_sel_i == SRC_VX || src_sel_i == SRC_VI) ? scalar_rep : vs1_i;

    assign lane_bus.valid = valid_i;
    assign lane_bus.op    = op_i;
    assign lane_bus.sew   = sew_i;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_bus.vs1_elem[k] = op1[k*ELEN +: ELEN];
            lane_bus.vs2_elem[k] = vs2_i[k*ELEN +: ELEN];
            // Lane k holds global elements k*(64/SEW) and up
            case (sew_i)
                SEW_8:   lane_bus.mask_elem[k] = mask_i[k*8 +: 8];
                SEW_16:  lane_bus.mask_elem[k] = {4'b0, mask_i[k*4 +: 4]};
                SEW_32:  lane_bus.mask_elem[k] = {6'b0, mask_i[k*2 +: 2]};
                default: lane_bus.mask_elem[k] = {7'b0, mask_i[k]};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/simd_pkg.sv
/*
 * Shared constants of the vector unit: element width and immediate width,
 * the SEW, opcode and operand source enums, and the compare opcode test
 */
`default_nettype none

package simd_pkg;

    localparam int ELEN  = 64;  // Bits per lane element
    localparam int IMM_W = 5;   // vi-form immediate

    // Encoding is log2(SEW/8), result merge relies on it for shifts
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VMERGE  = 4'd5,
        VMSEQ   = 4'd6,
        VMSLT   = 4'd7,
        VMSLTU  = 4'd8,
        VMV_X_S = 4'd9
    } simd_op_e;

    // Source of operand 1
    typedef enum logic [1:0] {
        SRC_VV = 2'd0,  // vs1
        SRC_VX = 2'd1,  // rs1
        SRC_VI = 2'd2   // immediate
    } src_sel_e;

    function automatic logic is_compare(input simd_op_e op);
        return (op == VMSEQ) || (op == VMSLT) || (op == VMSLTU);
    endfunction

endpackage

`default_nettype wire

// File: hdl/simd_result_merge.sv
/*
 * Result merge: registered sideband, compare bit packing, tail fill,
 * undisturbed masking and vmv.x.s scalar extraction
 */
`timescale 1ns/10ps
`default_nettype none

module simd_result_merge #(
    parameter int VLEN = 128
) (
    input  logic                                                 clk_i,
    input  logic                                                 rstn_i,
    input  logic                                                 valid_i,
    input  simd_pkg::simd_op_e                                   op_i,
    input  simd_pkg::sew_e                                       sew_i,
    input  logic [VLEN-1:0]                                      old_vd_i,
    input  logic [VLEN-1:0]                                      mask_i,
    input  logic                                                 use_mask_i,
    input  logic [VLEN/simd_pkg::ELEN-1:0][simd_pkg::ELEN-1:0]   lane_elem_i,
    input  logic [VLEN/simd_pkg::ELEN-1:0][7:0]                  lane_cmp_i,
    output logic                                                 vresult_valid_o,
    output logic [VLEN-1:0]                                      vresult_o,
    output logic                                                 scalar_valid_o,
    output logic [63:0]                                          scalar_o
);
    import simd_pkg::*;

    localparam int LANES = VLEN / ELEN;

    logic            valid_q;
    simd_op_e        op_q;
    sew_e            sew_q;
    logic            use_mask_q;
    logic [VLEN-1:0] old_vd_q;
    logic [VLEN-1:0] mask_q;

    logic [VLEN-1:0] lane_vec;
    logic [VLEN-1:0] cmp_packed;
    logic [VLEN-1:0] cmp_res;
    logic [VLEN-1:0] vec_res;
    logic [ELEN-1:0] elem0;

    // Sideband follows the lanes by one cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= 1'b0;
            op_q       <= VADD;
            sew_q      <= SEW_8;
            use_mask_q <= 1'b0;
        end else begin
            valid_q    <= valid_i;
            op_q       <= op_i;
            sew_q      <= sew_i;
            use_mask_q <= use_mask_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            old_vd_q <= old_vd_i;
            mask_q   <= mask_i;
        end
    end

    assign lane_vec = lane_elem_i;
    assign elem0    = lane_elem_i[0];

    // Global element i lands in bit i, tail bits stay one
    always_comb begin
        cmp_packed = '1;
        for (int k = 0; k < LANES; k++) begin
            case (sew_q)
                SEW_8:   cmp_packed[k*8 +: 8] = lane_cmp_i[k];
                SEW_16:  cmp_packed[k*4 +: 4] = lane_cmp_i[k][3:0];
                SEW_32:  cmp_packed[k*2 +: 2] = lane_cmp_i[k][1:0];
                default: cmp_packed[k]        = lane_cmp_i[k][0];
            endcase
        end
    end

    always_comb begin
        int shift;
        int nelem;
        shift   = 3 + int'(sew_q);  // log2 of SEW in bits
        nelem   = VLEN >> shift;
        cmp_res = cmp_packed;
        vec_res = lane_vec;
        for (int b = 0; b < VLEN; b++) begin
            if (use_mask_q && b < nelem && !mask_q[b]) begin
                cmp_res[b] = old_vd_q[b];
            end
            // Bit b belongs to element b >> shift
            if (use_mask_q && !mask_q[b >> shift]) begin
                vec_res[b] = old_vd_q[b];
            end
        end
    end

    always_comb begin
        if (is_compare(op_q)) begin
            vresult_o = cmp_res;
        end else if (op_q == VMERGE) begin
            vresult_o = lane_vec;  // Lanes have already applied the mask
        end else begin
            vresult_o = vec_res;
        end
    end

    always_comb begin
        case (sew_q)
            SEW_8:   scalar_o = {{56{elem0[7]}}, elem0[7:0]};
            SEW_16:  scalar_o = {{48{elem0[15]}}, elem0[15:0]};
            SEW_32:  scalar_o = {{32{elem0[31]}}, elem0[31:0]};
            default: scalar_o = elem0;
        endcase
    end

    assign vresult_valid_o = valid_q && (op_q != VMV_X_S);
    assign scalar_valid_o  = valid_q && (op_q == VMV_X_S);

endmodule

`default_nettype wire

// File: hdl/simd_unit.sv
/*
 * Vector unit top: operand prep, one lane per 64 bits and result merge
 */
`timescale 1ns/10ps
`default_nettype none

module simd_unit #(
    parameter int VLEN = 128
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       valid_i,
    input  simd_pkg::simd_op_e         op_i,
    input  simd_pkg::sew_e             sew_i,
    input  simd_pkg::src_sel_e         src_sel_i,
    input  logic [VLEN-1:0]            vs1_i,
    input  logic [VLEN-1:0]            vs2_i,
    input  logic [VLEN-1:0]            old_vd_i,
    input  logic [VLEN-1:0]            mask_i,
    input  logic                       use_mask_i,
    input  logic [63:0]                rs1_i,
    input  logic [simd_pkg::IMM_W-1:0] imm_i,
    output logic                       vresult_valid_o,
    output logic [VLEN-1:0]            vresult_o,
    output logic                       scalar_valid_o,
    output logic [63:0]                scalar_o
);
    import simd_pkg::*;

    localparam int LANES = VLEN / ELEN;

    logic [LANES-1:0][ELEN-1:0] lane_elem;
    logic [LANES-1:0][7:0]      lane_cmp;

    simd_lane_if #(.VLEN(VLEN)) lane_bus ();

    simd_operand_prep #(.VLEN(VLEN)) i_simd_operand_prep (
        .valid_i   (valid_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .src_sel_i (src_sel_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .mask_i    (mask_i),
        .rs1_i     (rs1_i),
        .imm_i     (imm_i),
        .lane_bus  (lane_bus.prep)
    );

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        simd_lane #(
            .VLEN     (VLEN),
            .LANE_IDX (k)
        ) i_simd_lane (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .lane_bus (lane_bus.lane),
            .elem_o   (lane_elem[k]),
            .cmp_o    (lane_cmp[k])
        );
    end

    simd_result_merge #(.VLEN(VLEN)) i_simd_result_merge (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .sew_i           (sew_i),
        .old_vd_i        (old_vd_i),
        .mask_i          (mask_i),
        .use_mask_i      (use_mask_i),
        .lane_elem_i     (lane_elem),
        .lane_cmp_i      (lane_cmp),
        .vresult_valid_o (vresult_valid_o),
        .vresult_o       (vresult_o),
        .scalar_valid_o  (scalar_valid_o),
        .scalar_o        (scalar_o)
    );

endmodule

`default_nettype wire

// File: tb/simd_unit_properties.sv
/*
 * Concurrent assertions on the output valids of the vector unit,
 * bound to every simd_unit instance
 */
`timescale 1ns/10ps
`default_nettype none

module simd_unit_properties (
    input wire logic clk_i,
    input wire logic rstn_i,
    input wire logic valid_i,
    input wire logic vresult_valid_o,
    input wire logic scalar_valid_o
);

    // Both valids low while reset is applied and right after it
    a_low_in_reset: assert property (@(posedge clk_i)
        !rstn_i |-> (!vresult_valid_o && !scalar_valid_o))
        else $error("output valid high during reset");

    a_low_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!vresult_valid_o && !scalar_valid_o))
        else $error("output valid high right after reset");

    a_one_hot_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(vresult_valid_o && scalar_valid_o))
        else $error("vector and scalar valid high together");

    // Exactly one output pulse one cycle after each accepted input
    a_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i |=> (vresult_valid_o ^ scalar_valid_o))
        else $error("no output one cycle after valid_i");

    a_no_spurious: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (vresult_valid_o || scalar_valid_o) |-> $past(valid_i))
        else $error("output valid without valid_i one cycle earlier");

endmodule

bind simd_unit simd_unit_properties i_simd_unit_properties (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .valid_i         (valid_i),
    .vresult_valid_o (vresult_valid_o),
    .scalar_valid_o  (scalar_valid_o)
);

`default_nettype wire

// File: tb/simd_unit_tb.sv
/*
 * Testbench of the vector unit: random stimulus per test group,
 * reference model of the element rules and a comparing process
 */
`timescale 1ns/10ps
`default_nettype none

module simd_unit_tb;
    import simd_pkg::*;

    localparam int VLEN = 256;

    logic clk_i;
    logic rstn_i;
    logic valid_i;
    simd_op_e op_i;
    sew_e sew_i;
    src_sel_e src_sel_i;
    logic [VLEN-1:0] vs1_i;
    logic [VLEN-1:0] vs2_i;
    logic [VLEN-1:0] old_vd_i;
    logic [VLEN-1:0] mask_i;
    logic use_mask_i;
    logic [63:0] rs1_i;
    logic [IMM_W-1:0] imm_i;
    logic vresult_valid_o;
    logic [VLEN-1:0] vresult_o;
    logic scalar_valid_o;
    logic [63:0] scalar_o;

    integer seed = 42;
    int err_cnt = 0;
    int chk_cnt = 0;
    int err_base = 0;
    int chk_base = 0;
    logic in_flight = 1'b0;  // valid_i seen at the previous falling edge
    logic [VLEN-1:0] exp_q[$];
    simd_op_e exp_op_q[$];
    logic [VLEN-1:0] v1;
    logic [VLEN-1:0] v2;
    logic [VLEN-1:0] t1;
    logic [VLEN-1:0] t2;

    tb_clock_gen i_tb_clock_gen (
        .clk_o  (clk_i),
        .rstn_o (rstn_i)
    );

    simd_unit #(.VLEN(VLEN)) i_simd_unit (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .sew_i           (sew_i),
        .src_sel_i       (src_sel_i),
        .vs1_i           (vs1_i),
        .vs2_i           (vs2_i),
        .old_vd_i        (old_vd_i),
        .mask_i          (mask_i),
        .use_mask_i      (use_mask_i),
        .rs1_i           (rs1_i),
        .imm_i           (imm_i),
        .vresult_valid_o (vresult_valid_o),
        .vresult_o       (vresult_o),
        .scalar_valid_o  (scalar_valid_o),
        .scalar_o        (scalar_o)
    );

    // Expected vector, or the scalar in the low 64 bits for vmv.x.s
    function automatic logic [VLEN-1:0] ref_result(
        input simd_op_e op, input sew_e sew, input src_sel_e src,
        input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2,
        input logic [VLEN-1:0] old_vd, input logic [VLEN-1:0] mask,
        input logic use_mask, input logic [63:0] rs1, input logic [IMM_W-1:0] imm);
        int sw;
        int nelem;
        logic [63:0] wmask;
        logic [63:0] scal;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic c;
        logic [VLEN-1:0] res;
        sw    = 8 << int'(sew);
        nelem = VLEN / sw;
        wmask = (sw == 64) ? '1 : ((64'd1 << sw) - 64'd1);
        scal  = (src == SRC_VI) ? {{(64-IMM_W){imm[IMM_W-1]}}, imm} : rs1;
        res   = '1;  // Compare tail stays all ones
        for (int i = 0; i < nelem; i++) begin
            a  = (vs2 >> (i * sw)) & wmask;
            b  = (src == SRC_VV) ? ((vs1 >> (i * sw)) & wmask) : (scal & wmask);
            sa = a << (64 - sw);
            sa = sa >>> (64 - sw);
            sb = b << (64 - sw);
            sb = sb >>> (64 - sw);
            r  = a;
            c  = 1'b0;
            case (op)
                VADD:    r = a + b;
                VSUB:    r = a - b;
                VAND:    r = a & b;
                VOR:     r = a | b;
                VXOR:    r = a ^ b;
                VMERGE:  r = mask[i] ? b : a;  // Always masked, inactive takes vs2
                VMSEQ:   c = (a == b);
                VMSLT:   c = (sa < sb);
                VMSLTU:  c = (a < b);
                default: r = a;
            endcase
            if (op == VMSEQ || op == VMSLT || op == VMSLTU) begin
                res[i] = (use_mask && !mask[i]) ? old_vd[i] : c;
            end else begin
                if (op != VMERGE && use_mask && !mask[i]) r = old_vd >> (i * sw);
                for (int j = 0; j < sw; j++) res[i*sw + j] = r[j];
            end
        end
        if (op == VMV_X_S) begin
            sa = (vs2[63:0] & wmask) << (64 - sw);
            sa = sa >>> (64 - sw);
            res = '0;
            res[63:0] = sa;
        end
        return res;
    endfunction

    task automatic rand_vec(output logic [VLEN-1:0] v);
        for (int i = 0; i < VLEN / 32; i++) v[i*32 +: 32] = $random(seed);
    endtask

    task automatic issue(input simd_op_e op, input sew_e sew, input src_sel_e src,
                         input logic use_mask, input logic [VLEN-1:0] vs1,
                         input logic [VLEN-1:0] vs2);
        logic [VLEN-1:0] old_vd;
        logic [VLEN-1:0] mask;
        logic [63:0] rs1;
        logic [IMM_W-1:0] imm;
        rand_vec(old_vd);
        rand_vec(mask);
        rs1 = {$random(seed), $random(seed)};
        imm = IMM_W'($random(seed));
        @(posedge clk_i);
        valid_i    <= 1'b1;
        op_i       <= op;
        sew_i      <= sew;
        src_sel_i  <= src;
        vs1_i      <= vs1;
        vs2_i      <= vs2;
        old_vd_i   <= old_vd;
        mask_i     <= mask;
        use_mask_i <= use_mask;
        rs1_i      <= rs1;
        imm_i      <= imm;
        exp_q.push_back(ref_result(op, sew, src, vs1, vs2, old_vd, mask, use_mask, rs1, imm));
        exp_op_q.push_back(op);
    endtask

    task automatic idle();
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    // Waits for all queued results, then reports the test
    task automatic end_test(input string name);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 50) begin
            @(posedge clk_i);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR at %0t: timeout, %0d results never arrived", $time, exp_q.size());
            err_cnt++;
        end
        $display("test %s: %0d checks, %0d errors", name, chk_cnt - chk_base, err_cnt - err_base);
        chk_base = chk_cnt;
        err_base = err_cnt;
    endtask

    // Outputs settle after the rising edge, so compare on the falling edge
    always @(negedge clk_i) begin : compare_outputs
        logic [VLEN-1:0] exp_v;
        simd_op_e exp_op;
        if (rstn_i) begin
            if (vresult_valid_o || scalar_valid_o) begin
                if (!in_flight) begin
                    $display("ERROR at %0t: output valid without an input one cycle earlier",
                             $time);
                    err_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t: output valid with no result expected", $time);
                    err_cnt++;
                end else begin
                    exp_v  = exp_q.pop_front();
                    exp_op = exp_op_q.pop_front();
                    chk_cnt++;
                    if ((exp_op == VMV_X_S) != scalar_valid_o ||
                        vresult_valid_o == scalar_valid_o) begin
                        $display("ERROR at %0t: wrong valid output for %s", $time, exp_op.name());
                        err_cnt++;
                    end else if (scalar_valid_o && scalar_o !== exp_v[63:0]) begin
                        $display("MISMATCH at %0t: %s scalar got %h expected %h",
                                 $time, exp_op.name(), scalar_o, exp_v[63:0]);
                        err_cnt++;
                    end else if (vresult_valid_o && vresult_o !== exp_v) begin
                        $display("MISMATCH at %0t: %s got %h expected %h",
                                 $time, exp_op.name(), vresult_o, exp_v);
                        err_cnt++;
                    end
                end
            end else if (in_flight) begin
                $display("ERROR at %0t: no output one cycle after the input", $time);
                err_cnt++;
                if (exp_q.size() != 0) begin
                    exp_v  = exp_q.pop_front();
                    exp_op = exp_op_q.pop_front();
                end
            end
            in_flight = valid_i;
        end else if (vresult_valid_o || scalar_valid_o) begin
            $display("ERROR at %0t: output valid high during reset", $time);
            err_cnt++;
        end
    end

    initial begin
        int t;
        valid_i    = 1'b0;
        op_i       = VADD;
        sew_i      = SEW_8;
        src_sel_i  = SRC_VV;
        vs1_i      = '0;
        vs2_i      = '0;
        old_vd_i   = '0;
        mask_i     = '0;
        use_mask_i = 1'b0;
        rs1_i      = '0;
        imm_i      = '0;
        t = 0;
        while (rstn_i !== 1'b1 && t < 20) begin
            @(posedge clk_i);
            t++;
        end
        if (rstn_i !== 1'b1) begin
            $display("ERROR at %0t: reset was never released", $time);
            err_cnt++;
        end

        for (int o = 0; o < 5; o++) begin  // VADD to VXOR
            for (int s = 0; s < 4; s++) begin
                for (int r = 0; r < 2; r++) begin
                    rand_vec(v1);
                    rand_vec(v2);
                    issue(simd_op_e'(o), sew_e'(s), SRC_VV, 1'b0, v1, v2);
                    idle();
                end
            end
        end
        end_test("alu ops vector-vector");

        for (int o = 0; o < 5; o += 4) begin  // VADD and VXOR
            for (int s = 0; s < 4; s++) begin
                for (int sc = 1; sc < 3; sc++) begin
                    rand_vec(v1);
                    rand_vec(v2);
                    issue(simd_op_e'(o), sew_e'(s), src_sel_e'(sc), 1'b0, v1, v2);
                    idle();
                end
            end
        end
        end_test("scalar and immediate operands");

        for (int o = 0; o < 6; o++) begin  // Up to VMERGE
            for (int s = 0; s < 4; s++) begin
                rand_vec(v1);
                rand_vec(v2);
                issue(simd_op_e'(o), sew_e'(s), src_sel_e'((o + s) % 3), 1'b1, v1, v2);
                idle();
            end
        end
        end_test("masking and merge");

        for (int o = 6; o < 9; o++) begin  // Compares
            for (int s = 0; s < 4; s++) begin
                for (int r = 0; r < 2; r++) begin
                    rand_vec(v1);
                    rand_vec(v2);
                    rand_vec(t1);
                    rand_vec(t2);
                    v1 = v2 ^ (v1 & t1 & t2);  // Few flipped bits, so some elements match
                    issue(simd_op_e'(o), sew_e'(s), SRC_VV, r[0], v1, v2);
                    idle();
                end
            end
        end
        end_test("compares to mask");

        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < 2; r++) begin
                rand_vec(v1);
                rand_vec(v2);
                issue(VMV_X_S, sew_e'(s), SRC_VV, 1'b0, v1, v2);
                idle();
            end
        end
        end_test("vmv.x.s");

        for (int n = 0; n < 24; n++) begin  // No idle cycles in between
            rand_vec(v1);
            rand_vec(v2);
            issue(simd_op_e'($unsigned($random(seed)) % 10), sew_e'($unsigned($random(seed)) % 4),
                  src_sel_e'($unsigned($random(seed)) % 3), ($random(seed) & 1) != 0, v1, v2);
        end
        idle();
        end_test("back-to-back");

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
/*
 * Testbench clock and reset: 4 ns clock, active-low reset for 2 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;  // Released on a rising edge
    end

endmodule

`default_nettype wire
